//--- scr_pkg.sv
/*
 * Scroll layer package
 * widths, page geometry, CPU register map, the shadow register
 * struct and the fetch FSM states shared by the tilemap layer
 */
package scr_pkg;

    // line and mirror geometry
    localparam int line_w         = 256;  // rendered columns per line
    localparam int flip_last_line = 223;  // vertical mirror point
    localparam int flip_last_col  = 255;  // horizontal mirror point

    // cpu register map
    localparam logic [1:0] reg_pages = 2'd0;
    localparam logic [1:0] reg_hscr  = 2'd1;
    localparam logic [1:0] reg_vscr  = 2'd2;

    typedef logic [8:0]  xpos_t;       // column inside a 512 pixel page pair
    typedef logic [7:0]  ypos_t;       // line inside a 256 line page pair
    typedef logic [2:0]  page_t;       // map page number
    typedef logic [13:0] map_addr_t;   // page, tile row (5), tile column (6)
    typedef logic [15:0] map_word_t;   // prio 15, palette 12:6, code 12:0
    typedef logic [15:0] tile_addr_t;  // tile code + row inside tile
    typedef logic [31:0] tile_word_t;  // planes 2..0 in bytes 2..0, byte 3 unused
    typedef logic [10:0] pixel_t;      // prio, palette (7), plane bits 2..0

    // scroll registers as seen by the fetch engine
    typedef struct packed {
        page_t pg_ul;   // no overflow
        page_t pg_ur;   // horizontal overflow
        page_t pg_ll;   // vertical overflow
        page_t pg_lr;   // both overflow
        xpos_t hscr;
        ypos_t vscr;
    } scr_cfg_t;

    // map/tile fetch sequence
    typedef enum logic [2:0] {
        st_idle,       // line done, nothing written
        st_map_addr,   // map address setup
        st_map_wait,   // wait map_ok
        st_tile_wait,  // wait tile_ok
        st_shift       // pixels out to the line buffer
    } fetch_st_t;

endpackage

//--- scr_regs.sv
/*
 * Scroll registers
 * CPU-written page and scroll values plus a shadow copy
 * that only changes at line start
 */
`timescale 1ns/1ps

module scr_regs import scr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_we,
    input  logic [1:0]  cpu_addr,
    input  logic [15:0] cpu_data,
    input  logic        start,
    output scr_cfg_t    cfg
);

    scr_cfg_t live;       // what the cpu last wrote
    logic     start_l;
    logic     start_rise;

    assign start_rise = start & ~start_l;

    // cpu side, one write per strobe cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live <= '0;
        end else if (cpu_we) begin
            case (cpu_addr)
                reg_pages: begin
                    // one nibble per page, top bit ignored
                    live.pg_ul <= cpu_data[14:12];
                    live.pg_ur <= cpu_data[10:8];
                    live.pg_ll <= cpu_data[6:4];
                    live.pg_lr <= cpu_data[2:0];
                end
                reg_hscr: live.hscr <= cpu_data[8:0];
                reg_vscr: live.vscr <= cpu_data[7:0];
                default: ;  // address 3 unmapped
            endcase
        end
    end

    // shadow copy, held for the whole line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_l <= 1'b0;
            cfg     <= '0;
        end else begin
            start_l <= start;
            if (start_rise) begin
                cfg <= live;  // writes mid-line show up next line
            end
        end
    end

endmodule

//--- scr_tile_fetch.sv
/*
 * Tilemap fetch engine
 * walks one line of 256 columns, reads map and tile words from
 * external memory and shifts pixels into the line buffer
 */
`timescale 1ns/1ps

module scr_tile_fetch import scr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       flip,
    input  ypos_t      vrender,
    input  scr_cfg_t   cfg,
    output map_addr_t  map_addr,
    input  map_word_t  map_data,
    input  logic       map_ok,
    output tile_addr_t tile_addr,
    input  tile_word_t tile_data,
    input  logic       tile_ok,
    output logic       wr_en,
    output xpos_t      wr_addr,
    output pixel_t     wr_data,
    output logic       bad
);

    fetch_st_t       st;
    logic            start_l;
    logic            start_rise;
    logic            done;          // line finished or never started
    ypos_t           vline;         // line being drawn, flip already applied
    xpos_t           hscan;         // screen column being written
    xpos_t           hpos;          // scrolled column
    ypos_t           vpos;          // scrolled line
    logic            hov;           // borrow of hscan - hscr
    logic            vov;           // carry of line + vscr
    page_t           page;
    logic [7:0]      attr;          // priority + palette of current tile
    logic [2:0][7:0] planes;        // one shifter per bitplane
    logic            last_col;
    logic            last_in_tile;

    assign start_rise = start & ~start_l;
    assign done       = (st == st_idle);

    // scrolled positions, overflow bits pick the page
    assign {hov, hpos} = {1'b0, hscan} - {1'b0, cfg.hscr};
    assign {vov, vpos} = {1'b0, vline} + {1'b0, cfg.vscr};

    always_comb begin
        case ({vov, hov})
            2'b00:   page = cfg.pg_ul;
            2'b01:   page = cfg.pg_ur;
            2'b10:   page = cfg.pg_ll;
            default: page = cfg.pg_lr;
        endcase
    end

    assign last_col     = (hscan == xpos_t'(line_w - 1));
    assign last_in_tile = &hpos[2:0];  // tile edge in page space

    // one pixel per shift cycle, MSB of each plane first
    assign wr_en   = (st == st_shift);
    assign wr_addr = hscan;
    assign wr_data = {attr, planes[2][7], planes[1][7], planes[0][7]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_l   <= 1'b0;
            st        <= st_idle;   // done out of reset, no writes
            vline     <= '0;
            hscan     <= '0;
            map_addr  <= '0;
            tile_addr <= '0;
            bad       <= 1'b0;
        end else begin
            start_l <= start;
            if (start_rise) begin
                // new line always wins, even over a late one
                vline <= flip ? ypos_t'(flip_last_line) - vrender : vrender;
                hscan <= '0;
                bad   <= ~done;
                st    <= st_map_addr;
            end else begin
                case (st)
                    st_map_addr: begin
                        map_addr <= {page, vpos[7:3], hpos[8:3]};
                        st       <= st_map_wait;
                    end
                    st_map_wait: begin
                        if (map_ok) begin  // address held until then
                            tile_addr <= {map_data[12:0], vpos[2:0]};
                            st        <= st_tile_wait;
                        end
                    end
                    st_tile_wait: begin
                        if (tile_ok) begin
                            st <= st_shift;
                        end
                    end
                    st_shift: begin
                        hscan <= hscan + 1'b1;
                        if (last_col) begin
                            st  <= st_idle;
                            bad <= 1'b0;  // line made it in time
                        end else if (last_in_tile) begin
                            st <= st_map_addr;  // next tile
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // tile payload
    always_ff @(posedge clk) begin
        if (st == st_map_wait && map_ok) begin
            attr <= {map_data[15], map_data[12:6]};
        end
        if (st == st_tile_wait && tile_ok) begin
            // skip the pixels left of hpos when hscr is not tile aligned
            for (int p = 0; p < 3; p++) begin
                planes[p] <= tile_data[8*p +: 8] << hpos[2:0];
            end
        end else if (st == st_shift) begin
            for (int p = 0; p < 3; p++) begin
                planes[p] <= planes[p] << 1;
            end
        end
    end

endmodule

//--- scr_linebuf.sv
/*
 * Double line buffer
 * one half is drawn by the fetch engine while the video side
 * reads and erases the other, halves swap at line start
 */
`timescale 1ns/1ps

module scr_linebuf import scr_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   flip,
    input  logic   wr_en,
    input  xpos_t  wr_addr,
    input  pixel_t wr_data,
    input  xpos_t  hdump,
    output pixel_t pxl
);

    pixel_t mem [2][line_w];  // two line halves
    logic   start_l;
    logic   bank;             // half being drawn
    logic   rd_bank;          // half on screen
    xpos_t  rd_col;

    assign rd_bank = ~bank;

    // mirror columns before the read
    assign rd_col = flip ? xpos_t'(flip_last_col) - hdump : hdump;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_l <= 1'b0;
            bank    <= 1'b0;
        end else begin
            start_l <= start;
            if (start & ~start_l) begin
                bank <= ~bank;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[bank][wr_addr[7:0]] <= wr_data;
        end
        pxl                        <= mem[rd_bank][rd_col[7:0]];
        mem[rd_bank][rd_col[7:0]]  <= '0;  // erase on read
    end

endmodule

//--- scr_layer.sv
/*
 * Scrolling tilemap layer
 * scroll registers, map/tile fetch engine and double line buffer
 */
`timescale 1ns/1ps

module scr_layer import scr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // cpu write port
    input  logic        cpu_we,
    input  logic [1:0]  cpu_addr,
    input  logic [15:0] cpu_data,
    // video timing
    input  logic        start,     // line start, rising edge
    input  logic        flip,
    input  ypos_t       vrender,
    input  xpos_t       hdump,
    // map memory
    output map_addr_t   map_addr,
    input  map_word_t   map_data,
    input  logic        map_ok,
    // tile memory
    output tile_addr_t  tile_addr,
    input  tile_word_t  tile_data,
    input  logic        tile_ok,
    // video out
    output pixel_t      pxl,
    output logic        bad        // previous line late
);

    scr_cfg_t cfg;      // shadow registers
    logic     wr_en;
    xpos_t    wr_addr;
    pixel_t   wr_data;

    scr_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .start    (start),
        .cfg      (cfg)
    );

    scr_tile_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .flip      (flip),
        .vrender   (vrender),
        .cfg       (cfg),
        .map_addr  (map_addr),
        .map_data  (map_data),
        .map_ok    (map_ok),
        .tile_addr (tile_addr),
        .tile_data (tile_data),
        .tile_ok   (tile_ok),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .bad       (bad)
    );

    scr_linebuf u_linebuf (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .flip    (flip),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .hdump   (hdump),
        .pxl     (pxl)
    );

endmodule

//--- scr_checker.sv
/*
 * Fetch engine checker
 * no buffer writes while waiting on memory, map address held under
 * back-pressure, writes of one line land on consecutive columns
 */
`timescale 1ns/1ps

module scr_checker import scr_pkg::*; (
    input logic      clk,
    input logic      rst,
    input fetch_st_t st,
    input logic      start_rise,
    input logic      wr_en,
    input xpos_t     wr_addr,
    input map_addr_t map_addr,
    input logic      map_ok
);

    xpos_t last_wr;  // column of the previous write
    logic  seen_wr;  // a write already happened in this line

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_wr <= '0;
            seen_wr <= 1'b0;
        end else if (start_rise) begin
            seen_wr <= 1'b0;  // new line, no previous column
        end else if (wr_en) begin
            last_wr <= wr_addr;
            seen_wr <= 1'b1;
        end
    end

    no_write_in_wait: assert property (
        @(posedge clk) disable iff (rst)
        (st == st_map_wait || st == st_tile_wait) |-> !wr_en
    ) else $error("line buffer write during a memory wait");

    map_addr_held: assert property (
        @(posedge clk) disable iff (rst)
        (st == st_map_wait && !map_ok) |=> $stable(map_addr)
    ) else $error("map address moved before map_ok");

    columns_in_order: assert property (
        @(posedge clk) disable iff (rst)
        (wr_en && seen_wr) |-> (wr_addr == last_wr + 1'b1)
    ) else $error("write column skipped or repeated");

endmodule

//--- tb_clkgen.sv
/*
 * Testbench clock and reset
 * 20 ns clock, reset held high for the first five cycles
 */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // release away from the active edge
    end

endmodule

//--- tb_scr.sv
/*
 * Tilemap layer testbench
 * map and tile memory models with random ok delays, a table of
 * scroll setups, line buffer sweeps checked against a pixel model
 */
`timescale 1ns/1ps

module tb_scr import scr_pkg::*; ();

    // one stimulus row
    typedef struct packed {
        logic [15:0] pages;    // page nibbles ul, ur, ll, lr
        xpos_t       hscr;
        ypos_t       vscr;
        logic        flip;
        ypos_t       vrender;
        logic        early;    // second start 100 cycles in
    } row_t;

    logic        clk;
    logic        rst;
    logic        cpu_we;
    logic [1:0]  cpu_addr;
    logic [15:0] cpu_data;
    logic        start;
    logic        flip;
    ypos_t       vrender;
    xpos_t       hdump;
    map_addr_t   map_addr;
    map_word_t   map_data = '0;
    logic        map_ok = 1'b0;
    tile_addr_t  tile_addr;
    tile_word_t  tile_data = '0;
    logic        tile_ok = 1'b0;
    pixel_t      pxl;
    logic        bad;

    row_t        rows [6];
    int          window = 4000;           // render time given to each line
    int          limit = 6 * 5000;        // rows times cycles per row
    int          cycles = 0;
    integer      seed = 32'hb3e405d8;
    logic [31:0] rnd;
    map_addr_t   map_seen = '1;           // address the map delay belongs to
    tile_addr_t  tile_seen = '1;
    logic [1:0]  map_cnt = 2'd0;
    logic [1:0]  tile_cnt = 2'd0;

    tb_clkgen u_clk (
        .clk (clk),
        .rst (rst)
    );

    scr_layer dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .start     (start),
        .flip      (flip),
        .vrender   (vrender),
        .hdump     (hdump),
        .map_addr  (map_addr),
        .map_data  (map_data),
        .map_ok    (map_ok),
        .tile_addr (tile_addr),
        .tile_data (tile_data),
        .tile_ok   (tile_ok),
        .pxl       (pxl),
        .bad       (bad)
    );

    bind scr_tile_fetch scr_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .start_rise (start_rise),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .map_addr   (map_addr),
        .map_ok     (map_ok)
    );

    // map contents mixed from the address
    function automatic map_word_t map_word(input map_addr_t a);
        logic [15:0] h;
        h = {2'b00, a} * 16'h2b6d;
        h = h ^ {h[8:0], 7'h35};
        return h;
    endfunction

    // tile contents from a second mix
    function automatic tile_word_t tile_word(input tile_addr_t a);
        logic [31:0] h;
        h = {a, ~a} * 32'h045d9f3b;
        h = h ^ (h >> 15);
        return h;
    endfunction

    // pixel expected at screen column col for one table row
    function automatic pixel_t expect_pixel(input row_t r, input int col);
        ypos_t      vline;
        logic [9:0] hx;  // borrow in bit 9
        logic [8:0] vy;  // carry in bit 8
        page_t      pg;
        map_word_t  mw;
        tile_word_t tw;
        int         b;
        vline = r.flip ? ypos_t'(flip_last_line - int'(r.vrender)) : r.vrender;
        hx    = {1'b0, xpos_t'(col)} - {1'b0, r.hscr};
        vy    = {1'b0, vline} + {1'b0, r.vscr};
        case ({vy[8], hx[9]})
            2'b00:   pg = r.pages[14:12];
            2'b01:   pg = r.pages[10:8];
            2'b10:   pg = r.pages[6:4];
            default: pg = r.pages[2:0];
        endcase
        mw = map_word({pg, vy[7:3], hx[8:3]});
        tw = tile_word({mw[12:0], vy[2:0]});
        b  = 7 - int'(hx[2:0]);  // leftmost pixel sits in bit 7
        return {mw[15], mw[12:6], tw[16 + b], tw[8 + b], tw[b]};
    endfunction

    // memories answer a held address after 0..3 extra cycles
    always @(negedge clk) begin
        rnd = $random(seed);
        if (map_addr != map_seen) begin
            map_seen <= map_addr;
            map_cnt  <= rnd[1:0];
            map_ok   <= 1'b0;
            map_data <= map_word(map_addr);
        end else if (map_cnt != 2'd0) begin
            map_cnt <= map_cnt - 1'b1;
        end else begin
            map_ok <= 1'b1;
        end
        if (tile_addr != tile_seen) begin
            tile_seen <= tile_addr;
            tile_cnt  <= rnd[3:2];
            tile_ok   <= 1'b0;
            tile_data <= tile_word(tile_addr);
        end else if (tile_cnt != 2'd0) begin
            tile_cnt <= tile_cnt - 1'b1;
        end else begin
            tile_ok <= 1'b1;
        end
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", limit);
            abort_run();
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_data = data;
        @(negedge clk);
        cpu_we   = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;  // edge already taken on the rising clock
    endtask

    // hdump 0..255 with each pxl checked one clock later
    task automatic sweep_line(input row_t r, input bit erased, input int idx);
        pixel_t exp;
        int     col;
        for (int i = 0; i <= line_w; i++) begin
            if (i > 0) begin
                col = r.flip ? flip_last_col - (i - 1) : i - 1;
                exp = erased ? '0 : expect_pixel(r, col);
                check_value(32'(pxl), 32'(exp),
                            $sformatf("row %0d hdump %0d erased %0d", idx, i - 1, erased));
            end
            if (i < line_w) begin
                hdump = xpos_t'(i);
            end
            @(negedge clk);
        end
    endtask

    initial begin
        row_t cur;
        cpu_we   = 1'b0;
        cpu_addr = 2'd0;
        cpu_data = 16'd0;
        start    = 1'b0;
        flip     = 1'b0;
        vrender  = '0;
        hdump    = '0;
        //          pages     hscr     vscr    flip  vrender early
        rows[0] = '{16'h0123, 9'd0,   8'd0,   1'b0, 8'd10,  1'b0};  // plain page ul
        rows[1] = '{16'h4567, 9'd261, 8'h30,  1'b0, 8'd40,  1'b0};  // all columns borrow
        rows[2] = '{16'h1357, 9'd77,  8'hf0,  1'b0, 8'd100, 1'b0};  // carry with ll/lr split
        rows[3] = '{16'h2604, 9'd13,  8'd200, 1'b1, 8'd30,  1'b0};  // flipped
        rows[4] = '{16'h7531, 9'd300, 8'd5,   1'b0, 8'd200, 1'b1};  // late line
        rows[5] = '{16'h6420, 9'd0,   8'd0,   1'b1, 8'd250, 1'b0};  // flip wraps line
        @(negedge rst);
        @(negedge clk);
        check_value(32'(bad), 32'd0, "bad after reset");
        foreach (rows[r]) begin
            cur     = rows[r];
            flip    = cur.flip;
            vrender = cur.vrender;
            write_reg(reg_pages, cur.pages);
            write_reg(reg_hscr, 16'(cur.hscr));
            write_reg(reg_vscr, 16'(cur.vscr));
            pulse_start();
            if (cur.early) begin
                wait_cycles(99);
                pulse_start();  // first line far from done
                check_value(32'(bad), 32'd1, $sformatf("row %0d bad on late line", r));
            end
            // mid-line writes go to the live registers only
            wait_cycles(50);
            write_reg(reg_pages, ~cur.pages);
            write_reg(reg_hscr, 16'(~cur.hscr));
            write_reg(reg_vscr, 16'(~cur.vscr));
            wait_cycles(window - 53);
            check_value(32'(bad), 32'd0, $sformatf("row %0d bad after full line", r));
            pulse_start();  // drawn half to the video side
            sweep_line(cur, 1'b0, r);
            sweep_line(cur, 1'b1, r);  // erased by the first pass
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- compile.f
scr_pkg.sv
scr_regs.sv
scr_tile_fetch.sv
scr_linebuf.sv
scr_layer.sv
scr_checker.sv
tb_clkgen.sv
tb_scr.sv

//--- Makefile
# Verilator build and run for the scrolling tilemap layer

SIM      := verilator
TOP      := tb_scr
FILELIST := compile.f
FLAGS    := --binary --timing --assert -j 0
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJDIR)
